// ==== hdl/privcheck_pkg.sv ====
`default_nettype none

package privcheck_pkg;

  // privilege encodings, only U and M exist
  localparam logic [1:0] MODE_U = 2'b00;
  localparam logic [1:0] MODE_M = 2'b11;

  // misa extension bits
  localparam int MISA_U_POS = 20;
  localparam int MISA_S_POS = 18;
  localparam int MISA_N_POS = 13;

  // mstatus fields
  localparam int MPP_POS  = 11;
  localparam int MPP_LEN  = 2;
  localparam int SPP_POS  = 8;
  localparam int MPRV_POS = 17;
  localparam int TW_POS   = 21;
  localparam int XS_POS   = 15;
  localparam int XS_LEN   = 2;
  localparam int FS_POS   = 13;
  localparam int FS_LEN   = 2;
  localparam int SD_POS   = 31;

  // system instruction words
  localparam logic [31:0] MRET_IDATA    = 32'h3020_0073;
  localparam logic [31:0] URET_IDATA    = 32'h0020_0073;
  localparam logic [31:0] WFI_IDATA     = 32'h1050_0073;
  localparam logic [31:0] WFE_IDATA     = 32'h8c00_0073;
  localparam logic [31:0] CUSTOM0_IDATA = 32'h8c00_0073;
  localparam logic [31:0] CUSTOM1_IDATA = 32'hcc00_0073;
  localparam logic [31:0] CUSTOM_IMASK  = 32'hfc00_707f;

  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

  // N-extension and delegation CSRs, none of them implemented
  localparam logic [11:0] CSRADDR_USTATUS  = 12'h000;
  localparam logic [11:0] CSRADDR_UIE      = 12'h004;
  localparam logic [11:0] CSRADDR_UTVEC    = 12'h005;
  localparam logic [11:0] CSRADDR_USCRATCH = 12'h040;
  localparam logic [11:0] CSRADDR_UEPC     = 12'h041;
  localparam logic [11:0] CSRADDR_UCAUSE   = 12'h042;
  localparam logic [11:0] CSRADDR_UTVAL    = 12'h043;
  localparam logic [11:0] CSRADDR_UIP      = 12'h044;
  localparam logic [11:0] CSRADDR_MEDELEG  = 12'h302;
  localparam logic [11:0] CSRADDR_MIDELEG  = 12'h303;

  // exception causes
  localparam logic [5:0] EXC_ILLEGAL_INSN    = 6'd2;
  localparam logic [5:0] EXC_INSTR_FAULT     = 6'd1;
  localparam logic [5:0] EXC_LOAD_ALIGN_EXT  = 6'd24;
  localparam logic [5:0] EXC_STORE_ALIGN_EXT = 6'd25;

  // bit positions in the report flags
  localparam int RULE_MISA       = 0;
  localparam int RULE_MODE       = 1;
  localparam int RULE_SPP        = 2;
  localparam int RULE_MPP        = 3;
  localparam int RULE_MPRV       = 4;
  localparam int RULE_EXT_BITS   = 5;
  localparam int RULE_MCOUNTEREN = 6;
  localparam int RULE_ILLEGAL    = 7;
  localparam int RULE_NEXT_MODE  = 8;

  localparam int NUM_RULES = 9;
  localparam int ORDER_W   = 64;

  // one instruction word, seen as a plain system op or as a csr op
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } sys;
    struct packed {
      logic [11:0] csr;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } csr;
  } insn_word_u;

endpackage

`default_nettype wire

// ==== hdl/insn_rule_check.sv ====
`default_nettype none

module insn_rule_check
  import privcheck_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_n,
  input  wire logic       load,
  input  wire logic [1:0] mode,
  input  wire insn_word_u insn,
  input  wire logic       trap,
  input  wire logic [5:0] exc_cause,
  input  wire logic       mstatus_tw,
  output logic            illegal_err,
  output logic            mret_ok,
  output logic            trapped
);

  logic sys_plain;
  logic is_mret;
  logic is_uret;
  logic is_wfi;
  logic is_wfe;
  logic is_custom;
  logic is_csr;
  logic csr_high_level;
  logic csr_absent;
  logic in_umode;
  logic must_be_illegal;
  logic cause_illegal;
  logic cause_higher;
  logic took_illegal;
  logic miss_illegal;
  logic wfi_wrongly_illegal;

  // system op with rs1, funct3 and rd all zero
  assign sys_plain = (insn.sys.opcode == OPCODE_SYSTEM) &&
                     (insn.sys.funct3 == 3'b000) &&
                     (insn.sys.rs1 == 5'd0) &&
                     (insn.sys.rd == 5'd0);

  assign is_mret = sys_plain && ({insn.sys.funct7, insn.sys.rs2} == MRET_IDATA[31:20]);
  assign is_uret = sys_plain && ({insn.sys.funct7, insn.sys.rs2} == URET_IDATA[31:20]);
  assign is_wfi  = sys_plain && ({insn.sys.funct7, insn.sys.rs2} == WFI_IDATA[31:20]);

  // wfe sits inside the custom0 space but is a supported op
  assign is_wfe    = (insn == WFE_IDATA);
  assign is_custom = !is_wfe &&
                     (((insn & CUSTOM_IMASK) == CUSTOM0_IDATA) ||
                      ((insn & CUSTOM_IMASK) == CUSTOM1_IDATA));

  // csrrw/s/c and their immediate forms
  assign is_csr = (insn.csr.opcode == OPCODE_SYSTEM) &&
                  !(insn.csr.funct3 inside {3'b000, 3'b100});

  // address bits 9:8 give the lowest mode allowed to touch the CSR
  assign csr_high_level = (insn.csr.csr[9:8] != MODE_U);

  assign csr_absent = insn.csr.csr inside {
    CSRADDR_USTATUS, CSRADDR_UIE, CSRADDR_UTVEC, CSRADDR_USCRATCH,
    CSRADDR_UEPC, CSRADDR_UCAUSE, CSRADDR_UTVAL, CSRADDR_UIP,
    CSRADDR_MEDELEG, CSRADDR_MIDELEG
  };

  assign in_umode = (mode == MODE_U);

  always_comb begin
    must_be_illegal = 1'b0;
    if (in_umode) begin
      if (is_mret || is_uret || is_custom) begin
        must_be_illegal = 1'b1;
      end
      if (is_wfi && mstatus_tw) begin
        must_be_illegal = 1'b1;
      end
      if (is_csr && csr_high_level) begin
        must_be_illegal = 1'b1;
      end
    end
    // missing CSRs trap in every mode
    if (is_csr && csr_absent) begin
      must_be_illegal = 1'b1;
    end
  end

  assign cause_illegal = (exc_cause == EXC_ILLEGAL_INSN);
  assign cause_higher  = exc_cause inside {
    EXC_INSTR_FAULT, EXC_LOAD_ALIGN_EXT, EXC_STORE_ALIGN_EXT
  };

  // a higher priority fault can take the place of the illegal trap
  assign took_illegal = trap && (cause_illegal || cause_higher);
  assign miss_illegal = must_be_illegal && !took_illegal;

  assign wfi_wrongly_illegal = in_umode && is_wfi && !mstatus_tw && trap && cause_illegal;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      illegal_err <= 1'b0;
      mret_ok     <= 1'b0;
      trapped     <= 1'b0;
    end else if (load) begin
      illegal_err <= miss_illegal || wfi_wrongly_illegal;
      mret_ok     <= is_mret && !trap;
      trapped     <= trap;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/csr_state_check.sv ====
`default_nettype none

module csr_state_check
  import privcheck_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_n,
  input  wire logic                 load,
  input  wire logic [1:0]           mode,
  input  wire logic [31:0]          misa,
  input  wire logic [31:0]          mstatus_rdata,
  input  wire logic [31:0]          mstatus_wdata,
  input  wire logic [31:0]          mstatus_wmask,
  input  wire logic [31:0]          mcounteren,
  output logic [NUM_RULES-1:0]      state_flags,
  output logic [1:0]                mode_q,
  output logic [1:0]                mpp_q
);

  logic [31:0]          mstatus_post;
  logic [MPP_LEN-1:0]   mpp_post;
  logic [MPP_LEN-1:0]   mpp_read;
  logic [NUM_RULES-1:0] flags_d;

  // written bits come from wdata, all others keep the read value
  assign mstatus_post = (mstatus_wdata & mstatus_wmask) | (mstatus_rdata & ~mstatus_wmask);

  assign mpp_post = mstatus_post[MPP_POS +: MPP_LEN];
  assign mpp_read = mstatus_rdata[MPP_POS +: MPP_LEN];

  always_comb begin
    flags_d = '0;

    // U present, no S and no N
    flags_d[RULE_MISA] = !misa[MISA_U_POS] || misa[MISA_S_POS] || misa[MISA_N_POS];

    flags_d[RULE_MODE] = !(mode inside {MODE_U, MODE_M});

    // no S-mode, so SPP is hardwired
    flags_d[RULE_SPP] = mstatus_rdata[SPP_POS];

    flags_d[RULE_MPP] = !(mpp_post inside {MODE_U, MODE_M});

    // U-mode never runs with modified privilege
    flags_d[RULE_MPRV] = (mode == MODE_U) && mstatus_rdata[MPRV_POS];

    flags_d[RULE_EXT_BITS] = (mstatus_rdata[XS_POS +: XS_LEN] != '0) ||
                             (mstatus_rdata[FS_POS +: FS_LEN] != '0) ||
                             mstatus_rdata[SD_POS];

    flags_d[RULE_MCOUNTEREN] = (mcounteren != 32'd0);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_flags <= '0;
      mode_q      <= MODE_M;
      mpp_q       <= MODE_M;
    end else if (load) begin
      state_flags <= flags_d;
      mode_q      <= mode;
      mpp_q       <= mpp_read;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/report_merge.sv ====
`default_nettype none

module report_merge
  import privcheck_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_n,
  input  wire logic                 s1_valid,
  input  wire logic [ORDER_W-1:0]   s1_order,
  input  wire logic                 advance,
  input  wire logic                 illegal_err,
  input  wire logic                 mret_ok,
  input  wire logic                 trapped,
  input  wire logic [NUM_RULES-1:0] state_flags,
  input  wire logic [1:0]           mode,
  input  wire logic [1:0]           mpp,
  output logic                      out_valid,
  output logic [ORDER_W-1:0]        out_order,
  output logic [NUM_RULES-1:0]      out_flags
);

  logic [1:0]           exp_mode;
  logic                 exp_en;
  logic                 next_mode_err;
  logic                 consume;
  logic [NUM_RULES-1:0] merged;

  assign consume       = advance && s1_valid;
  assign next_mode_err = exp_en && (mode != exp_mode);

  always_comb begin
    merged = state_flags;
    merged[RULE_ILLEGAL]   = merged[RULE_ILLEGAL] | illegal_err;
    merged[RULE_NEXT_MODE] = merged[RULE_NEXT_MODE] | next_mode_err;
  end

  // expected mode of the next retirement
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      exp_mode <= MODE_M;
      exp_en   <= 1'b1;
    end else if (consume) begin
      if (trapped) begin
        exp_mode <= MODE_M;
        exp_en   <= 1'b1;
      end else if (mret_ok) begin
        exp_mode <= mpp;
        exp_en   <= 1'b1;
      end else begin
        exp_en <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (consume) begin
      out_order <= s1_order;
      out_flags <= merged;
    end
  end

  // a valid report never carries an unknown flag
  a_flags_known: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    out_valid |-> !$isunknown(out_flags)
  );

endmodule

`default_nettype wire

// ==== hdl/priv_monitor_top.sv ====
`default_nettype none

module priv_monitor_top
  import privcheck_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_n,
  input  wire logic                 in_valid,
  output logic                      in_ready,
  input  wire logic [ORDER_W-1:0]   in_order,
  input  wire logic [1:0]           in_mode,
  input  wire logic [31:0]          in_insn,
  input  wire logic                 in_trap,
  input  wire logic [5:0]           in_exc_cause,
  input  wire logic [31:0]          in_misa,
  input  wire logic [31:0]          in_mstatus_rdata,
  input  wire logic [31:0]          in_mstatus_wdata,
  input  wire logic [31:0]          in_mstatus_wmask,
  input  wire logic [31:0]          in_mcounteren,
  output logic                      out_valid,
  input  wire logic                 out_ready,
  output logic [ORDER_W-1:0]        out_order,
  output logic [NUM_RULES-1:0]      out_flags
);

  logic                 advance;
  logic                 load;
  logic                 s1_valid;
  logic [ORDER_W-1:0]   s1_order;
  logic                 illegal_err;
  logic                 mret_ok;
  logic                 trapped;
  logic [NUM_RULES-1:0] state_flags;
  logic [1:0]           s1_mode;
  logic [1:0]           s1_mpp;

  // whole pipe moves unless the report is stuck
  assign advance  = !out_valid || out_ready;
  assign in_ready = advance;
  assign load     = in_valid && advance;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      s1_order <= in_order;
    end
  end

  insn_rule_check insn_rule_check_i (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .load        (load),
    .mode        (in_mode),
    .insn        (in_insn),
    .trap        (in_trap),
    .exc_cause   (in_exc_cause),
    .mstatus_tw  (in_mstatus_rdata[TW_POS]),
    .illegal_err (illegal_err),
    .mret_ok     (mret_ok),
    .trapped     (trapped)
  );

  csr_state_check csr_state_check_i (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .load          (load),
    .mode          (in_mode),
    .misa          (in_misa),
    .mstatus_rdata (in_mstatus_rdata),
    .mstatus_wdata (in_mstatus_wdata),
    .mstatus_wmask (in_mstatus_wmask),
    .mcounteren    (in_mcounteren),
    .state_flags   (state_flags),
    .mode_q        (s1_mode),
    .mpp_q         (s1_mpp)
  );

  report_merge report_merge_i (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .s1_valid    (s1_valid),
    .s1_order    (s1_order),
    .advance     (advance),
    .illegal_err (illegal_err),
    .mret_ok     (mret_ok),
    .trapped     (trapped),
    .state_flags (state_flags),
    .mode        (s1_mode),
    .mpp         (s1_mpp),
    .out_valid   (out_valid),
    .out_order   (out_order),
    .out_flags   (out_flags)
  );

  // a stalled report is held until the consumer takes it
  a_report_held: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_order)
  );

endmodule

`default_nettype wire

// ==== testbench/priv_monitor_tests.svh ====
  localparam int KIND_PLAIN  = 0;
  localparam int KIND_MRET   = 1;
  localparam int KIND_URET   = 2;
  localparam int KIND_CUSTOM = 3;
  localparam int KIND_WFI    = 4;
  localparam int KIND_CSR    = 5;

  // mstatus bits that no rule looks at
  localparam logic [31:0] MSTATUS_FREE = 32'h7fdc_06ff;
  localparam logic [31:0] MISA_BITS    = (32'h1 << MISA_U_POS) | (32'h1 << MISA_S_POS) |
                                         (32'h1 << MISA_N_POS);

  // record under construction
  logic [1:0]  r_mode;
  logic [31:0] r_insn;
  logic        r_trap;
  logic [5:0]  r_cause;
  logic [31:0] r_misa;
  logic [31:0] r_rdata;
  logic [31:0] r_wdata;
  logic [31:0] r_wmask;
  logic [31:0] r_mcnt;
  int          r_kind;
  logic [11:0] r_csr;

  // legal record, an ALU op with random neutral fields
  task automatic build_clean(input logic [1:0] mode);
    r_mode       = mode;
    r_kind       = KIND_PLAIN;
    r_csr        = '0;
    r_insn       = $random(seed);
    r_insn[6:0]  = 7'h33;
    r_trap       = 1'b0;
    r_cause      = '0;
    r_misa       = ($random(seed) & ~MISA_BITS) | (32'h1 << MISA_U_POS);
    r_rdata      = ($random(seed) & MSTATUS_FREE) | (32'(MODE_M) << MPP_POS);
    r_wmask      = $random(seed) & MSTATUS_FREE;
    r_wdata      = $random(seed);
    r_mcnt       = '0;
  endtask

  task automatic build_system(input logic [1:0] mode, input int kind);
    build_clean(mode);
    r_kind = kind;
    case (kind)
      KIND_MRET: r_insn = MRET_IDATA;
      KIND_URET: r_insn = URET_IDATA;
      KIND_CUSTOM: r_insn = CUSTOM1_IDATA;
      default: r_insn = WFI_IDATA;
    endcase
  endtask

  // csrrs x1 on the given address
  task automatic build_csr(input logic [1:0] mode, input logic [11:0] addr);
    build_clean(mode);
    r_kind = KIND_CSR;
    r_csr  = addr;
    r_insn = {addr, 5'd0, 3'b010, 5'd1, OPCODE_SYSTEM};
  endtask

  task automatic set_trap(input logic [5:0] cause);
    r_trap  = 1'b1;
    r_cause = cause;
  endtask

  // expected flags, and the mode the next record must have
  task automatic predict_flags(output logic [NUM_RULES-1:0] flags);
    logic [31:0] post;
    logic        tw;
    logic        csr_high;
    logic        csr_none;
    logic        must;
    logic        took;
    post     = (r_wdata & r_wmask) | (r_rdata & ~r_wmask);
    tw       = r_rdata[TW_POS];
    flags    = '0;
    flags[RULE_MISA]       = !r_misa[MISA_U_POS] || r_misa[MISA_S_POS] || r_misa[MISA_N_POS];
    flags[RULE_MODE]       = (r_mode != MODE_U) && (r_mode != MODE_M);
    flags[RULE_SPP]        = r_rdata[SPP_POS];
    flags[RULE_MPP]        = post[MPP_POS +: MPP_LEN] inside {2'b01, 2'b10};
    flags[RULE_MPRV]       = (r_mode == MODE_U) && r_rdata[MPRV_POS];
    flags[RULE_EXT_BITS]   = (r_rdata[XS_POS +: 2] != 2'b00) ||
                             (r_rdata[FS_POS +: 2] != 2'b00) || r_rdata[SD_POS];
    flags[RULE_MCOUNTEREN] = (r_mcnt != 32'd0);
    csr_high = (r_csr[9:8] != 2'b00);
    csr_none = r_csr inside {12'h000, 12'h004, 12'h005, 12'h040, 12'h041, 12'h042,
                             12'h043, 12'h044, 12'h302, 12'h303};
    must     = (r_kind == KIND_CSR) && csr_none;
    if (r_mode == MODE_U) begin
      must = must || (r_kind inside {KIND_MRET, KIND_URET, KIND_CUSTOM}) ||
             (r_kind == KIND_WFI && tw) || (r_kind == KIND_CSR && csr_high);
    end
    took = r_trap && (r_cause inside {6'd1, 6'd2, 6'd24, 6'd25});
    flags[RULE_ILLEGAL]    = (must && !took) ||
                             (r_mode == MODE_U && r_kind == KIND_WFI && !tw &&
                              r_trap && r_cause == 6'd2);
    flags[RULE_NEXT_MODE]  = exp_en && (r_mode != exp_mode);
    if (r_trap) begin
      exp_mode = MODE_M;
      exp_en   = 1'b1;
    end else if (r_kind == KIND_MRET) begin
      exp_mode = r_rdata[MPP_POS +: MPP_LEN];
      exp_en   = 1'b1;
    end else begin
      exp_en = 1'b0;
    end
  endtask

  // called on a falling edge, returns on the one after the transfer
  task automatic push_record();
    logic [NUM_RULES-1:0] flags;
    predict_flags(flags);
    exp_order_q.push_back(next_order);
    exp_flags_q.push_back(flags);
    in_valid         = 1'b1;
    in_order         = next_order;
    in_mode          = r_mode;
    in_insn          = r_insn;
    in_trap          = r_trap;
    in_exc_cause     = r_cause;
    in_misa          = r_misa;
    in_mstatus_rdata = r_rdata;
    in_mstatus_wdata = r_wdata;
    in_mstatus_wmask = r_wmask;
    in_mcounteren    = r_mcnt;
    next_order++;
    do @(posedge clk_i); while (!in_ready);
    @(negedge clk_i);
  endtask

  task automatic end_test(input string name, input int err_start);
    in_valid = 1'b0;
    while (exp_order_q.size() != 0) @(negedge clk_i);
    tests_run++;
    $display("test %s done, %0d errors", name, errors - err_start);
  endtask

  task automatic test_clean();
    int err_start;
    err_start = errors;
    apply_reset();
    repeat (6) begin
      build_clean(MODE_M);
      push_record();
    end
    end_test("clean_stream", err_start);
  endtask

  task automatic test_csr_state();
    int err_start;
    err_start = errors;
    apply_reset();
    build_clean(MODE_M);
    push_record();
    for (int i = 0; i < 7; i++) begin
      build_clean(MODE_M);
      case (i)
        0: r_misa[MISA_S_POS] = 1'b1;
        1: r_mode = 2'b10;
        2: r_rdata[SPP_POS] = 1'b1;
        3: begin
          r_wmask[MPP_POS +: MPP_LEN] = 2'b11;
          r_wdata[MPP_POS +: MPP_LEN] = 2'b10;
        end
        4: begin
          r_mode            = MODE_U;
          r_rdata[MPRV_POS] = 1'b1;
        end
        5: r_rdata[FS_POS +: 2] = 2'b01;
        default: r_mcnt = 32'h1;
      endcase
      push_record();
    end
    end_test("csr_state", err_start);
  endtask

  task automatic build_illegal_case(input int c);
    case (c)
      0: build_system(MODE_U, KIND_MRET);
      1: build_system(MODE_U, KIND_URET);
      2: build_system(MODE_U, KIND_CUSTOM);
      3: begin
        build_system(MODE_U, KIND_WFI);
        r_rdata[TW_POS] = 1'b1;
      end
      4: build_csr(MODE_U, 12'h300);
      default: build_csr(MODE_M, CSRADDR_USTATUS);
    endcase
  endtask

  task automatic test_illegal();
    int err_start;
    err_start = errors;
    apply_reset();
    build_clean(MODE_M);
    push_record();
    // cause 2, cause 24, then no trap at all
    for (int c = 0; c < 6; c++) begin
      for (int v = 0; v < 3; v++) begin
        build_illegal_case(c);
        if (v == 0) begin
          set_trap(EXC_ILLEGAL_INSN);
        end else if (v == 1) begin
          set_trap(EXC_LOAD_ALIGN_EXT);
        end
        push_record();
        build_clean(MODE_M);
        push_record();
      end
    end
    build_system(MODE_U, KIND_WFI);
    set_trap(EXC_ILLEGAL_INSN);
    push_record();
    end_test("illegal_insn", err_start);
  endtask

  task automatic test_sequencing();
    int err_start;
    err_start = errors;
    apply_reset();
    build_clean(MODE_U);
    push_record();
    build_clean(MODE_M);
    set_trap(6'd5);
    push_record();
    build_clean(MODE_U);
    push_record();
    for (int i = 0; i < 2; i++) begin
      build_system(MODE_M, KIND_MRET);
      r_rdata[MPP_POS +: MPP_LEN] = MODE_U;
      push_record();
      build_clean(i == 0 ? MODE_U : MODE_M);
      push_record();
    end
    end_test("sequencing", err_start);
  endtask

  task automatic test_backpressure();
    int err_start;
    err_start = errors;
    apply_reset();
    bp_on = 1'b1;
    for (int i = 0; i < 24; i++) begin
      build_clean((i % 3 == 2) ? MODE_U : MODE_M);
      if (i % 5 == 3) begin
        r_rdata[SPP_POS] = 1'b1;
      end
      if (i % 7 == 4) begin
        set_trap(EXC_ILLEGAL_INSN);
      end
      push_record();
    end
    end_test("backpressure", err_start);
    bp_on = 1'b0;
  endtask

// ==== testbench/priv_monitor_tb.sv ====
`default_nettype none

module priv_monitor_tb
  import privcheck_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // records over all tests set the run limit
  localparam int TOTAL_RECORDS = 83;
  localparam int CYCLE_LIMIT   = TOTAL_RECORDS * 4 + 200;

  logic                 clk_i = 1'b0;
  logic                 rst_n;
  logic                 in_valid;
  logic                 in_ready;
  logic [ORDER_W-1:0]   in_order;
  logic [1:0]           in_mode;
  logic [31:0]          in_insn;
  logic                 in_trap;
  logic [5:0]           in_exc_cause;
  logic [31:0]          in_misa;
  logic [31:0]          in_mstatus_rdata;
  logic [31:0]          in_mstatus_wdata;
  logic [31:0]          in_mstatus_wmask;
  logic [31:0]          in_mcounteren;
  logic                 out_valid;
  logic                 out_ready;
  logic [ORDER_W-1:0]   out_order;
  logic [NUM_RULES-1:0] out_flags;

  integer               seed;
  int                   errors;
  int                   tests_run;
  int                   reports_seen;
  int                   cycles = 0;
  logic                 bp_on;
  logic                 held;
  logic [ORDER_W-1:0]   held_order;
  logic [ORDER_W-1:0]   next_order;
  logic [1:0]           exp_mode;
  logic                 exp_en;
  logic [ORDER_W-1:0]   exp_order_q[$];
  logic [NUM_RULES-1:0] exp_flags_q[$];

  priv_monitor_top dut_i (
    .clk_i            (clk_i),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .in_order         (in_order),
    .in_mode          (in_mode),
    .in_insn          (in_insn),
    .in_trap          (in_trap),
    .in_exc_cause     (in_exc_cause),
    .in_misa          (in_misa),
    .in_mstatus_rdata (in_mstatus_rdata),
    .in_mstatus_wdata (in_mstatus_wdata),
    .in_mstatus_wmask (in_mstatus_wmask),
    .in_mcounteren    (in_mcounteren),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .out_order        (out_order),
    .out_flags        (out_flags)
  );

  always #50 clk_i = ~clk_i;

  // consumer stalls at random only while enabled
  always @(negedge clk_i) begin
    if (bp_on) begin
      out_ready <= ($random(seed) & 1) != 0;
    end else begin
      out_ready <= 1'b1;
    end
  end

  task automatic apply_reset();
    @(negedge clk_i);
    rst_n    = 1'b0;
    in_valid = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_n      = 1'b1;
    next_order = '0;
    exp_mode   = MODE_M;
    exp_en     = 1'b1;
  endtask

  task automatic check_report();
    logic [ORDER_W-1:0]   want_order;
    logic [NUM_RULES-1:0] want_flags;
    reports_seen++;
    if (exp_order_q.size() == 0) begin
      $display("unexpected report with order 0x%h, no record was pending", out_order);
      errors++;
    end else begin
      want_order = exp_order_q.pop_front();
      want_flags = exp_flags_q.pop_front();
      if (out_order !== want_order) begin
        $display("ERROR out_order: got 0x%h, expected 0x%h", out_order, want_order);
        errors++;
      end
      if (out_flags !== want_flags) begin
        $display("ERROR out_flags: got 0x%h, expected 0x%h at order 0x%h",
                 out_flags, want_flags, want_order);
        errors++;
      end
    end
  endtask

  // report transfers and stall holds checked on each rising edge
  always @(posedge clk_i) begin
    if (!rst_n) begin
      held <= 1'b0;
    end else begin
      if (held && !out_valid) begin
        $display("report was dropped while out_ready was low");
        errors++;
      end else if (held && out_order !== held_order) begin
        $display("ERROR out_order: changed from 0x%h to 0x%h while stalled",
                 held_order, out_order);
        errors++;
      end
      held       <= out_valid && !out_ready;
      held_order <= out_order;
      if (out_valid && out_ready) begin
        check_report();
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles with reports still missing", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

`include "priv_monitor_tests.svh"

  initial begin
    seed             = 32'hecc6_d471;
    errors           = 0;
    tests_run        = 0;
    reports_seen     = 0;
    bp_on            = 1'b0;
    rst_n            = 1'b0;
    in_valid         = 1'b0;
    in_order         = '0;
    in_mode          = MODE_M;
    in_insn          = '0;
    in_trap          = 1'b0;
    in_exc_cause     = '0;
    in_misa          = '0;
    in_mstatus_rdata = '0;
    in_mstatus_wdata = '0;
    in_mstatus_wmask = '0;
    in_mcounteren    = '0;
    out_ready        = 1'b1;

    test_clean();
    test_csr_state();
    test_illegal();
    test_sequencing();
    test_backpressure();

    $display("summary: %0d tests, %0d reports checked, %0d errors",
             tests_run, reports_seen, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+testbench
hdl/privcheck_pkg.sv
hdl/insn_rule_check.sv
hdl/csr_state_check.sv
hdl/report_merge.sv
hdl/priv_monitor_top.sv
testbench/priv_monitor_tb.sv

// ==== Bender.yml ====
package:
  name: priv_monitor

sources:
  - files:
      - hdl/privcheck_pkg.sv
      - hdl/insn_rule_check.sv
      - hdl/csr_state_check.sv
      - hdl/report_merge.sv
      - hdl/priv_monitor_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/priv_monitor_tb.sv
